/* build.f */
verilog/ahbPkg.sv
verilog/switchPkg.sv
verilog/masterDecode.sv
verilog/slaveArbiter.sv
verilog/responseRoute.sv
verilog/ahbSwitch.sv
testbench/ahbSwitch_asserts.sv
testbench/ahbSwitchTb.sv

/* testbench/switchTests.txt */
# mode(one/both) master dir(w/r) address(hex) data-or-expected-read(hex) resp(okay/error) waits(dec, r=random)
# both: this line and the next start together, master 0 line first
one  0 w 00000010 11111111 okay  0
one  0 r 00000010 11111111 okay  0
one  1 w 10000020 22222222 okay  1
one  1 r 10000020 22222222 okay  0
one  0 w 20000030 33333333 okay  2
one  0 r 20000030 33333333 okay  0
one  1 w 00000040 44444444 okay  0
one  0 r 00000040 44444444 okay  0
one  0 w 10000044 55555555 okay  0
one  1 r 10000044 55555555 okay  0
# unmapped, then slave 2 which master 1 may not reach
one  0 r 30000000 00000000 error 0
one  1 w 20000050 66666666 error 0
one  1 r 20000030 00000000 error 0
# same slave in the same cycle
both 0 w 00000060 77777777 okay  1
both 1 w 00000064 88888888 okay  0
both 0 r 00000064 88888888 okay  0
both 1 r 00000060 77777777 okay  2
# different slaves in the same cycle
both 0 w 10000070 99999999 okay  0
both 1 w 00000074 aaaaaaaa okay  3
both 0 r 00000074 aaaaaaaa okay  3
both 1 r 10000070 99999999 okay  0
# random wait states
one  0 w 20000080 bbbbbbbb okay  r
one  0 r 20000080 bbbbbbbb okay  r
both 0 w 00000088 cccccccc okay  r
both 1 w 1000008c dddddddd okay  r
both 0 r 1000008c dddddddd okay  r
both 1 r 00000088 cccccccc okay  r

/* testbench/ahbSwitchTb.sv */
// Two masters, three slaves; master 1 may not reach slave 2; test file path is relative to the project root
`timescale 1ns/1ps

module ahbSwitchTb;
  import ahbPkg::*;

  localparam int clkPeriod = 8;
  localparam int nM = 2;
  localparam int nS = 3;
  localparam haddr_t [nS-1:0] base = {32'h2000_0000, 32'h1000_0000, 32'h0000_0000};
  localparam haddr_t [nS-1:0] mask = {32'hF000_0000, 32'hF000_0000, 32'hF000_0000};
  localparam logic [nM-1:0][nS-1:0] allow = {3'b011, 3'b111};
  localparam addrPhase_t idlePhase = '{hsel: 1'b0, haddr: '0, hwrite: 1'b0,
                                       hsize: '0, htrans: TransIdle};

  logic HCLK;
  logic rstN;
  addrPhase_t [nM-1:0] mstReq;
  hdata_t [nM-1:0]     mstWdata;
  logic [nM-1:0]       mstReady;
  slvResp_t [nM-1:0]   mstResp;
  addrPhase_t [nS-1:0] slvReq;
  hdata_t [nS-1:0]     slvWdata;
  logic [nS-1:0]       slvReadyOut;
  slvResp_t [nS-1:0]   slvResp;

  // Test table from the file
  int     nTests;
  logic   loaded;
  logic   tBoth [64];
  int     tMst [64];
  logic   tWrite [64];
  haddr_t tAddr [64];
  hdata_t tData [64];
  logic   tResp [64];
  int     tWait [64];

  // Transfers in flight, seen by the slave models
  logic   pendLive [nM];
  haddr_t pendAddr [nM];
  logic   pendWrite [nM];
  int     pendWait [nM];
  int     pendSlave [nM];
  int     arrivalOrd [nM];
  int     arrivalCnt;

  int seed;
  int checks;
  int valueErrors;
  int otherErrors;

  ahbSwitch #(
    .numMasters (nM),
    .numSlaves  (nS),
    .slvBase    (base),
    .slvMask    (mask),
    .slaveAllow (allow)
  ) dut (.*);

  bind ahbSwitch ahbSwitchAsserts #(
    .numMasters (numMasters),
    .numSlaves  (numSlaves),
    .slvBase    (slvBase),
    .slvMask    (slvMask),
    .slaveAllow (slaveAllow)
  ) asserts (
    .HCLK(HCLK), .rstN(rstN), .mstResp(mstResp), .slvReq(slvReq),
    .mstRequest(mstRequest), .slvGrant(slvGrant));

  // HREADY loops back from each master's own response
  for (genvar m = 0; m < nM; m++)
  begin : readyLoop
    assign mstReady[m] = mstResp[m].hreadyOut;
  end

  initial
  begin
    HCLK = 1'b0;
    forever #(clkPeriod / 2) HCLK = ~HCLK;
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic checkData(input hdata_t got, input hdata_t exp, input string name);
    checks++;
    if (got !== exp)
    begin
      valueErrors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkResp(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp)
    begin
      valueErrors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkReady(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp)
    begin
      valueErrors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkAddr(input addrPhase_t got, input addrPhase_t exp, input string name);
    checks++;
    if (got !== exp)
    begin
      valueErrors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  // First slave whose masked base bits match, -1 when none or forbidden
  function automatic int findSlave(input haddr_t addr, input int m);
    for (int s = 0; s < nS; s++)
    begin
      if (((addr ^ base[s]) & mask[s]) == '0)
        return allow[m][s] ? s : -1;
    end
    return -1;
  endfunction

  //////////////////////////////////////////////////
  // Test file
  //////////////////////////////////////////////////

  task automatic loadTests();
    int fd;
    int n;
    int code;
    string line;
    string mode;
    string dir;
    string resp;
    string wStr;
    int mst;
    haddr_t addr;
    hdata_t data;
    fd = $fopen("testbench/switchTests.txt", "r");
    if (fd == 0)
    begin
      otherErrors++;
      $display("Cannot open the test file testbench/switchTests.txt");
      return;
    end
    while (!$feof(fd) && nTests < 64)
    begin
      code = $fgets(line, fd);
      // Skip comments and blank lines
      if (code == 0 || line.len() == 0 || line[0] == 8'h23)
        continue;
      n = $sscanf(line, "%s %d %s %h %h %s %s", mode, mst, dir, addr, data, resp, wStr);
      if (n != 7)
        continue;
      tBoth[nTests]  = (mode == "both");
      tMst[nTests]   = mst;
      tWrite[nTests] = (dir == "w");
      tAddr[nTests]  = addr;
      tData[nTests]  = data;
      tResp[nTests]  = (resp == "error") ? respError : respOkay;
      if (wStr == "r")
        tWait[nTests] = $unsigned($random(seed)) % 4;
      else
        n = $sscanf(wStr, "%d", tWait[nTests]);
      nTests++;
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // Master driver
  //////////////////////////////////////////////////

  // extra counts the cycles spent behind another master on the same slave
  task automatic runTransfer(input int i, input int extra);
    int m;
    int lows;
    m = tMst[i];
    lows = 0;
    @(negedge HCLK);
    pendAddr[m]  = tAddr[i];
    pendWrite[m] = tWrite[i];
    pendWait[m]  = tWait[i];
    pendSlave[m] = (tResp[i] == respError) ? -1 : findSlave(tAddr[i], m);
    pendLive[m]  = 1'b1;
    mstReq[m] = '{hsel: 1'b1, haddr: tAddr[i], hwrite: tWrite[i], hsize: 3'b010,
                  htrans: TransNonseq};
    // Data phase, write data held to the end
    @(negedge HCLK);
    mstReq[m] = idlePhase;
    if (tWrite[i])
      mstWdata[m] = tData[i];
    #3;
    while (!mstResp[m].hreadyOut)
    begin
      checkResp(mstResp[m].hresp, tResp[i], $sformatf("mstResp[%0d].hresp", m));
      lows++;
      if (lows > 40)
      begin
        otherErrors++;
        $display("Master %0d transfer to %h stuck with hreadyOut low", m, tAddr[i]);
        pendLive[m] = 1'b0;
        return;
      end
      @(negedge HCLK);
      #3;
    end
    checkResp(mstResp[m].hresp, tResp[i], $sformatf("mstResp[%0d].hresp", m));
    if (tResp[i] == respError && lows != 1)
    begin
      otherErrors++;
      $display("Master %0d ERROR response had %0d low cycles instead of one", m, lows);
    end
    // One cycle to the grant, then the slave's own wait states
    if (tResp[i] == respOkay && lows != 1 + extra + tWait[i])
    begin
      otherErrors++;
      $display("Master %0d transfer to %h had %0d low cycles instead of %0d", m, tAddr[i],
               lows, 1 + extra + tWait[i]);
    end
    if (tResp[i] == respOkay && !tWrite[i])
      checkData(mstResp[m].hrdata, tData[i], $sformatf("mstResp[%0d].hrdata", m));
    pendLive[m] = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Slave memory models
  //////////////////////////////////////////////////

  for (genvar s = 0; s < nS; s++)
  begin : slaveModel
    initial
    begin : model
      hdata_t mem [0:255];
      logic [255:0] memSet;
      logic inData;
      logic curWrite;
      haddr_t curAddr;
      int left;
      int hit;
      logic nextReady;
      hdata_t nextData;
      addrPhase_t expPhase;
      memSet = '0;
      inData = 1'b0;
      left = 0;
      nextReady = 1'b1;
      nextData = '0;
      forever
      begin
        @(negedge HCLK);
        slvResp[s] = '{hreadyOut: nextReady, hresp: respOkay, hrdata: nextData};
        // Just before the rising edge everything has settled
        #3;
        // Slave HREADY is its own HREADYOUT during a data phase, high otherwise
        checkReady(slvReadyOut[s], inData ? slvResp[s].hreadyOut : 1'b1,
                   $sformatf("slvReadyOut[%0d]", s));
        nextData = '0;
        if (inData && slvResp[s].hreadyOut)
        begin
          if (curWrite)
          begin
            mem[curAddr[9:2]] = slvWdata[s];
            memSet[curAddr[9:2]] = 1'b1;
          end
          inData = 1'b0;
          nextReady = 1'b1;
        end
        else if (inData)
        begin
          left--;
          nextReady = (left == 0);
        end
        if (slvReq[s].hsel && slvReq[s].htrans == TransNonseq && slvReadyOut[s])
        begin
          hit = -1;
          for (int m = 0; m < nM; m++)
          begin
            if (pendLive[m] && pendSlave[m] == s && pendAddr[m] == slvReq[s].haddr)
              hit = m;
          end
          left = 0;
          if (hit < 0)
          begin
            otherErrors++;
            $display("Slave %0d selected with no matching transfer at %h", s,
                     slvReq[s].haddr);
          end
          else
          begin
            expPhase = '{hsel: 1'b1, haddr: pendAddr[hit], hwrite: pendWrite[hit],
                         hsize: 3'b010, htrans: TransNonseq};
            checkAddr(slvReq[s], expPhase, $sformatf("slvReq[%0d]", s));
            left = pendWait[hit];
            arrivalOrd[hit] = arrivalCnt;
            arrivalCnt++;
          end
          inData = 1'b1;
          curAddr = slvReq[s].haddr;
          curWrite = slvReq[s].hwrite;
          nextReady = (left == 0);
        end
        // Unwritten words read back a pattern of the whole address
        if (inData && nextReady && !curWrite)
          nextData = memSet[curAddr[9:2]] ? mem[curAddr[9:2]] : (curAddr ^ 32'h5A5A_5A5A);
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    int i;
    int slaveA;
    int slaveB;
    int behind;
    seed = 32'h159b;
    nTests = 0;
    loaded = 1'b0;
    checks = 0;
    valueErrors = 0;
    otherErrors = 0;
    arrivalCnt = 0;
    rstN = 1'b0;
    mstReq = {nM{idlePhase}};
    mstWdata = '0;
    slvResp = {nS{34'h2_0000_0000}};
    for (int m = 0; m < nM; m++)
    begin
      pendLive[m] = 1'b0;
      arrivalOrd[m] = 0;
    end
    loadTests();
    loaded = 1'b1;
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    rstN = 1'b1;
    #3;
    // Idle outputs right out of reset
    for (int m = 0; m < nM; m++)
    begin
      checkReady(mstResp[m].hreadyOut, 1'b1, $sformatf("mstResp[%0d].hreadyOut", m));
      checkResp(mstResp[m].hresp, respOkay, $sformatf("mstResp[%0d].hresp", m));
    end
    for (int s = 0; s < nS; s++)
      checkAddr(slvReq[s], idlePhase, $sformatf("slvReq[%0d]", s));
    i = 0;
    while (i < nTests)
    begin
      if (tBoth[i] && i + 1 < nTests)
      begin
        // On a shared slave master 1 waits out the whole transfer of master 0
        slaveA = findSlave(tAddr[i], tMst[i]);
        slaveB = findSlave(tAddr[i + 1], tMst[i + 1]);
        behind = (slaveA >= 0 && slaveA == slaveB) ? 1 + tWait[i] : 0;
        fork
          runTransfer(i, 0);
          runTransfer(i + 1, behind);
        join
        // Same slave, so master 0 must reach it first
        if (pendSlave[0] >= 0 && pendSlave[0] == pendSlave[1] && arrivalOrd[0] > arrivalOrd[1])
        begin
          otherErrors++;
          $display("Master 1 reached slave %0d before master 0", pendSlave[0]);
        end
        i += 2;
      end
      else
      begin
        runTransfer(i, 0);
        i++;
      end
    end
    repeat (2) @(negedge HCLK);
    $display("Summary: %0d tests, %0d checks, %0d value errors, %0d other errors",
             nTests, checks, valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0 && nTests > 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    wait (loaded);
    #((nTests + 1) * 50 * clkPeriod);
    $display("Watchdog expired, the run did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* testbench/ahbSwitch_asserts.sv */
// Bound into ahbSwitch; reaches the internal request and grant matrices, checks only from the first cycle out of reset
`timescale 1ns/1ps

module ahbSwitchAsserts #(
  parameter int                                   numMasters = 2,
  parameter int                                   numSlaves  = 2,
  parameter ahbPkg::haddr_t [numSlaves-1:0]       slvBase    = '0,
  parameter ahbPkg::haddr_t [numSlaves-1:0]       slvMask    = '0,
  parameter logic [numMasters-1:0][numSlaves-1:0] slaveAllow = '1
)
(
  input logic                                  HCLK,
  input logic                                  rstN,
  input ahbPkg::slvResp_t [numMasters-1:0]     mstResp,
  input ahbPkg::addrPhase_t [numSlaves-1:0]    slvReq,
  input switchPkg::request_t [numMasters-1:0]  mstRequest,
  input logic [numSlaves-1:0][numMasters-1:0]  slvGrant
);
  import ahbPkg::*;

  //////////////////////////////////////////////////
  // Master ports
  //////////////////////////////////////////////////

  for (genvar m = 0; m < numMasters; m++)
  begin : perMaster
    // First ERROR cycle is always followed by the second
    errorSecond: assert property (@(posedge HCLK) disable iff (!rstN)
      (!mstResp[m].hreadyOut && mstResp[m].hresp == respError)
      |=> (mstResp[m].hreadyOut && mstResp[m].hresp == respError))
      else $error("master %0d ERROR response lost its second cycle", m);

    // Second ERROR cycle never comes alone
    errorFirst: assert property (@(posedge HCLK) disable iff (!rstN)
      (mstResp[m].hreadyOut && mstResp[m].hresp == respError)
      |-> $past(!mstResp[m].hreadyOut && mstResp[m].hresp == respError))
      else $error("master %0d ERROR response lacked its first cycle", m);

    idleMaster: assert property (@(posedge HCLK)
      $rose(rstN) |-> (mstResp[m].hreadyOut && mstResp[m].hresp == respOkay))
      else $error("master %0d response not idle after reset", m);

    // A grant only for an allowed slave whose region holds the address
    for (genvar s = 0; s < numSlaves; s++)
    begin : perSlave
      noSelect: assert property (@(posedge HCLK) disable iff (!rstN)
        slvGrant[s][m] |-> (slaveAllow[m][s] &&
          (((mstRequest[m].addr.haddr ^ slvBase[s]) & slvMask[s]) == '0)))
        else $error("slave %0d granted a bad target of master %0d", s, m);
    end
  end

  //////////////////////////////////////////////////
  // Slave ports
  //////////////////////////////////////////////////

  for (genvar s = 0; s < numSlaves; s++)
  begin : perSlavePort
    idleSlave: assert property (@(posedge HCLK)
      $rose(rstN) |-> (!slvReq[s].hsel && slvReq[s].htrans == TransIdle))
      else $error("slave %0d port not idle after reset", s);
  end

endmodule

/* verilog/ahbSwitch.sv */
// Default map suits two slaves only; override slvBase and slvMask with numSlaves, and loop each mstResp hreadyOut to mstReady
`timescale 1ns/1ps

module ahbSwitch #(
  parameter int                                   numMasters = 2,
  parameter int                                   numSlaves  = 2,
  parameter ahbPkg::haddr_t [numSlaves-1:0]       slvBase    = {32'h1000_0000, 32'h0000_0000},
  parameter ahbPkg::haddr_t [numSlaves-1:0]       slvMask    = {32'hF000_0000, 32'hF000_0000},
  parameter logic [numMasters-1:0][numSlaves-1:0] slaveAllow = '1
)
(
  input  logic                                HCLK,
  input  logic                                rstN,
  input  ahbPkg::addrPhase_t [numMasters-1:0] mstReq,
  input  ahbPkg::hdata_t [numMasters-1:0]     mstWdata,
  input  logic [numMasters-1:0]               mstReady,
  output ahbPkg::slvResp_t [numMasters-1:0]   mstResp,
  output ahbPkg::addrPhase_t [numSlaves-1:0]  slvReq,
  output ahbPkg::hdata_t [numSlaves-1:0]      slvWdata,
  output logic [numSlaves-1:0]                slvReadyOut,
  input  ahbPkg::slvResp_t [numSlaves-1:0]    slvResp
);
  import switchPkg::*;

  // Decoded requests, one per master
  request_t [numMasters-1:0] mstRequest;

  // Target and grant, master-major and slave-major views
  logic [numMasters-1:0][numSlaves-1:0] mstTarget;
  logic [numMasters-1:0][numSlaves-1:0] mstGrant;
  logic [numSlaves-1:0][numMasters-1:0] slvTarget;
  logic [numSlaves-1:0][numMasters-1:0] slvGrant;

  // Data-phase HREADY of each master
  logic [numMasters-1:0] mstReadyOut;

  //////////////////////////////////////////////////
  // Master side stages
  //////////////////////////////////////////////////

  for (genvar m = 0; m < numMasters; m++)
  begin : genMaster
    masterDecode #(
      .numSlaves  (numSlaves),
      .slvBase    (slvBase),
      .slvMask    (slvMask),
      .slaveAllow (slaveAllow[m])
    ) decode (
      .HCLK     (HCLK),
      .rstN     (rstN),
      .mstReq   (mstReq[m]),
      .mstReady (mstReady[m]),
      .granted  (|mstGrant[m]),
      .req      (mstRequest[m]),
      .target   (mstTarget[m])
    );

    responseRoute #(
      .numSlaves (numSlaves)
    ) route (
      .HCLK    (HCLK),
      .rstN    (rstN),
      .req     (mstRequest[m]),
      .grant   (mstGrant[m]),
      .slvResp (slvResp),
      .mstResp (mstResp[m])
    );

    assign mstReadyOut[m] = mstResp[m].hreadyOut;

    // Cross the matrices
    for (genvar s = 0; s < numSlaves; s++)
    begin : genCross
      assign slvTarget[s][m] = mstTarget[m][s];
      assign mstGrant[m][s]  = slvGrant[s][m];
    end
  end

  //////////////////////////////////////////////////
  // Slave side stages
  //////////////////////////////////////////////////

  for (genvar s = 0; s < numSlaves; s++)
  begin : genSlave
    slaveArbiter #(
      .numMasters (numMasters)
    ) arbiter (
      .HCLK        (HCLK),
      .rstN        (rstN),
      .req         (mstRequest),
      .target      (slvTarget[s]),
      .mstWdata    (mstWdata),
      .mstReadyOut (mstReadyOut),
      .slvResp     (slvResp[s]),
      .slvReq      (slvReq[s]),
      .slvWdata    (slvWdata[s]),
      .slvReadyOut (slvReadyOut[s]),
      .grant       (slvGrant[s])
    );
  end

endmodule

/* verilog/responseRoute.sv */
// One outstanding transfer per master; a bad target gets the two-cycle ERROR pair and no slave sees it
`timescale 1ns/1ps

module responseRoute #(
  parameter int numSlaves = 2
)
(
  input  logic                              HCLK,
  input  logic                              rstN,
  input  switchPkg::request_t               req,
  input  logic [numSlaves-1:0]              grant,
  input  ahbPkg::slvResp_t [numSlaves-1:0]  slvResp,
  output ahbPkg::slvResp_t                  mstResp
);
  import ahbPkg::*;
  import switchPkg::*;

  //////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////

  // Registered state, state seen this cycle, next state
  respState_t state;
  respState_t cur;
  respState_t nextState;

  // Slave owning the data phase, one-hot
  logic [numSlaves-1:0] owner;

  // That slave's response
  slvResp_t selResp;

  //////////////////////////////////////////////////
  // Current state
  //////////////////////////////////////////////////

  // A fresh request shows up while still Idle
  always_comb
  begin
    cur = state;
    if (state == Idle)
    begin
      if (req.badTarget)
        cur = Err1;
      else if (req.valid)
        cur = WaitGrant;
    end
  end

  always_comb
  begin
    selResp = '0;
    for (int s = 0; s < numSlaves; s++)
    begin
      if (owner[s])
        selResp = slvResp[s];
    end
  end

  //////////////////////////////////////////////////
  // Response to the master
  //////////////////////////////////////////////////

  always_comb
  begin
    mstResp.hrdata = '0;
    case (cur)
      WaitGrant:
      begin
        mstResp.hreadyOut = 1'b0;
        mstResp.hresp     = respOkay;
      end
      DataPhase:
        mstResp = selResp;
      // ERROR pair, low then high
      Err1:
      begin
        mstResp.hreadyOut = 1'b0;
        mstResp.hresp     = respError;
      end
      Err2:
      begin
        mstResp.hreadyOut = 1'b1;
        mstResp.hresp     = respError;
      end
      default:
      begin
        mstResp.hreadyOut = 1'b1;
        mstResp.hresp     = respOkay;
      end
    endcase
  end

  always_comb
  begin
    case (cur)
      WaitGrant: nextState = (|grant) ? DataPhase : WaitGrant;
      DataPhase: nextState = selResp.hreadyOut ? Idle : DataPhase;
      Err1:      nextState = Err2;
      default:   nextState = Idle;
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (!rstN)
      state <= Idle;
    else
      state <= nextState;
  end

  // Granting slave is the data-phase slave
  always_ff @(posedge HCLK)
  begin
    if ((cur == WaitGrant) && (|grant))
      owner <= grant;
  end

endmodule

/* verilog/slaveArbiter.sv */
// Fixed priority with master 0 highest; a new grant waits for the slave to end its data phase with hreadyOut high
`timescale 1ns/1ps

module slaveArbiter #(
  parameter int numMasters = 2
)
(
  input  logic                                HCLK,
  input  logic                                rstN,
  input  switchPkg::request_t [numMasters-1:0] req,
  input  logic [numMasters-1:0]               target,
  input  ahbPkg::hdata_t [numMasters-1:0]     mstWdata,
  input  logic [numMasters-1:0]               mstReadyOut,
  input  ahbPkg::slvResp_t                    slvResp,
  output ahbPkg::addrPhase_t                  slvReq,
  output ahbPkg::hdata_t                      slvWdata,
  output logic                                slvReadyOut,
  output logic [numMasters-1:0]               grant
);
  import ahbPkg::*;
  import switchPkg::*;

  //////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////

  // Masters with a live request aimed here
  logic [numMasters-1:0] reqHit;

  // Winner, one-hot
  logic [numMasters-1:0] pick;

  // Data-phase owner, one-hot
  logic [numMasters-1:0] owner;

  // Slave can take an address phase this cycle
  logic slvOpen;

  // Registered state, this cycle's phase, next state
  arbState_t state;
  arbState_t phase;
  arbState_t nextState;

  //////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////

  always_comb
  begin
    for (int m = 0; m < numMasters; m++)
    begin
      reqHit[m] = req[m].valid && target[m];
    end
  end

  // Lowest index wins
  assign pick = reqHit & (~reqHit + 1'b1);

  // Open when idle or when the current data phase completes now
  assign slvOpen = (state == Free) || slvResp.hreadyOut;

  always_comb
  begin
    phase = state;
    if (slvOpen)
    begin
      phase = (|reqHit) ? AddrOwned : Free;
    end
  end

  // Grant is a single address-phase cycle
  assign grant = (phase == AddrOwned) ? pick : '0;

  //////////////////////////////////////////////////
  // Slave side muxing
  //////////////////////////////////////////////////

  // Address phase of the granted master, idle otherwise
  always_comb
  begin
    slvReq = addrIdle;
    for (int m = 0; m < numMasters; m++)
    begin
      if (grant[m])
        slvReq = req[m].addr;
    end
  end

  // Write data follows the data-phase owner
  always_comb
  begin
    slvWdata = '0;
    if (state == DataOwned)
    begin
      for (int m = 0; m < numMasters; m++)
      begin
        if (owner[m])
          slvWdata = mstWdata[m];
      end
    end
  end

  // Owner's HREADY during a data phase, high otherwise so the slave samples
  assign slvReadyOut = (state == DataOwned) ? |(owner & mstReadyOut) : 1'b1;

  //////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////

  always_comb
  begin
    case (phase)
      AddrOwned: nextState = DataOwned;
      DataOwned: nextState = DataOwned;
      default:   nextState = Free;
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (!rstN)
      state <= Free;
    else
      state <= nextState;
  end

  // Remember who gets the following data phase
  always_ff @(posedge HCLK)
  begin
    if (phase == AddrOwned)
      owner <= pick;
  end

endmodule

/* verilog/masterDecode.sv */
// mstReady must be this master's HREADY, looped back from its mstResp hreadyOut; overlapping regions resolve to the lowest slave
`timescale 1ns/1ps

module masterDecode #(
  parameter int                             numSlaves  = 2,
  parameter ahbPkg::haddr_t [numSlaves-1:0] slvBase    = '0,
  parameter ahbPkg::haddr_t [numSlaves-1:0] slvMask    = '0,
  parameter logic [numSlaves-1:0]           slaveAllow = '1
)
(
  input  logic                 HCLK,
  input  logic                 rstN,
  input  ahbPkg::addrPhase_t   mstReq,
  input  logic                 mstReady,
  input  logic                 granted,
  output switchPkg::request_t  req,
  output logic [numSlaves-1:0] target
);
  import ahbPkg::*;

  //////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////

  // Address phase taken this cycle
  logic accept;

  // Region match per slave
  logic [numSlaves-1:0] hit;

  // Lowest matching slave only
  logic [numSlaves-1:0] firstHit;

  // Match left after the per-master allow mask
  logic [numSlaves-1:0] decTarget;
  logic                 decBad;

  // Held request
  logic       reqValid;
  logic       reqBad;
  addrPhase_t reqAddr;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  // Only NONSEQ is a real transfer, IDLE is ignored
  assign accept = mstReq.hsel && (mstReq.htrans == TransNonseq) && mstReady;

  always_comb
  begin
    for (int s = 0; s < numSlaves; s++)
    begin
      // Compare only the bits picked by the mask
      hit[s] = ((mstReq.haddr ^ slvBase[s]) & slvMask[s]) == '0;
    end
  end

  // Isolate lowest set bit
  assign firstHit = hit & (~hit + 1'b1);

  // Forbidden slave looks the same as no slave
  assign decTarget = firstHit & slaveAllow;
  assign decBad    = ~|decTarget;

  //////////////////////////////////////////////////
  // Request register
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK)
  begin
    if (!rstN)
    begin
      reqValid <= 1'b0;
      reqBad   <= 1'b0;
    end
    else if (accept)
    begin
      // A bad target never shows as valid
      reqValid <= !decBad;
      reqBad   <= decBad;
    end
    else
    begin
      // Held until some slave grants
      if (granted)
        reqValid <= 1'b0;
      // Error flag lasts one cycle
      reqBad <= 1'b0;
    end
  end

  // Payload, loaded on accept only
  always_ff @(posedge HCLK)
  begin
    if (accept)
    begin
      reqAddr <= mstReq;
      target  <= decTarget;
    end
  end

  assign req = '{valid: reqValid, badTarget: reqBad, addr: reqAddr};

endmodule

/* verilog/switchPkg.sv */
// Switch-internal types only; request_t carries one decoded single transfer, no burst state
package switchPkg;

  //////////////////////////////////////////////////
  // State machines
  //////////////////////////////////////////////////

  // Result stage, per master
  // Idle       nothing outstanding
  // WaitGrant  request decoded, no slave has granted yet
  // DataPhase  a slave owns this master's data phase
  // Err1 Err2  the two cycles of the ERROR response
  typedef enum logic [2:0] {
    Idle,
    WaitGrant,
    DataPhase,
    Err1,
    Err2
  } respState_t;

  // Execute stage, per slave
  // AddrOwned is the cycle an address phase is issued
  typedef enum logic [1:0] {
    Free,
    AddrOwned,
    DataOwned
  } arbState_t;

  //////////////////////////////////////////////////
  // Request bundle
  //////////////////////////////////////////////////

  // Decoded request from one master
  // valid only for a legal target, badTarget for one cycle otherwise
  typedef struct packed {
    logic               valid;
    logic               badTarget;
    ahbPkg::addrPhase_t addr;
  } request_t;

endpackage

/* verilog/ahbPkg.sv */
// Fixed 32-bit address and data; single transfers only (IDLE and NONSEQ); no HBURST, HPROT or HMASTLOCK
package ahbPkg;

  //////////////////////////////////////////////////
  // Field types
  //////////////////////////////////////////////////

  // Byte address on HADDR
  typedef logic [31:0] haddr_t;

  // One word on HWDATA or HRDATA
  typedef logic [31:0] hdata_t;

  // HSIZE encoding, byte up to word
  typedef logic [2:0] hsize_t;

  // HTRANS encoding
  typedef logic [1:0] htrans_t;

  // Only these two transfer types are carried
  localparam htrans_t TransIdle   = 2'b00;
  localparam htrans_t TransNonseq = 2'b10;

  // HRESP levels
  localparam logic respOkay  = 1'b0;
  localparam logic respError = 1'b1;

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////

  // Address phase, same layout on master and slave side
  typedef struct packed {
    logic    hsel;
    haddr_t  haddr;
    logic    hwrite;
    hsize_t  hsize;
    htrans_t htrans;
  } addrPhase_t;

  // Slave response, also what the switch returns to a master
  typedef struct packed {
    logic   hreadyOut;
    logic   hresp;
    hdata_t hrdata;
  } slvResp_t;

  // Deselected port
  localparam addrPhase_t addrIdle = '{hsel: 1'b0, haddr: '0, hwrite: 1'b0,
                                      hsize: '0, htrans: TransIdle};

endpackage
